// File: sim/core_testdata.hex
// Word 0 instruction count, then the program, then the store count,
// then one expected store per line as address and data.
00000026
24010005 24020003 00221821 ac030000
00222023 ac040004 00222824 00a13025
00c53826 ac070008 0041402a 00014900
01095021 ac0a000c 3c0b1234 356babcd
ac0b0010 240cffff 8c0d0004 01ac7021
ac0e0014 10220002 240f0007 25ef0001
ac0f0018 14220002 24100009 24100063
ac10001c 24110008 122f0002 24120011
24120022 ac120020 24000055 ac000024
1000ffff 00000000
// Expected stores.
0000000a
00000000 00000008
00000004 00000002
00000008 00000004
0000000c 00000051
00000010 1234abcd
00000014 00000001
00000018 00000008
0000001c 00000009
00000020 00000011
00000024 00000000

// File: filelist.f
design/mips_pkg.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/naive_core.sv
sim/tb_clock.sv
sim/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb -f filelist.f -o core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
exit 1

// File: sim/core_tb.sv
module core_tb
    import mips_pkg::*;
();

    localparam int IMEM_WORDS    = 64;
    localparam int DMEM_WORDS    = 64;
    localparam int TDATA_WORDS   = 128;
    localparam int QUIET_CYCLES  = 50;
    localparam int TIMEOUT_SLACK = 200;

    logic  clk;
    logic  rst_n;
    word_t ibus_address;
    word_t ibus_rddata;
    word_t dbus_address;
    logic  dbus_read;
    logic  dbus_write;
    word_t dbus_wrdata;
    word_t dbus_rddata;
    logic  dbus_stall;

    word_t tdata [TDATA_WORDS];
    word_t imem  [IMEM_WORDS];
    word_t dmem  [DMEM_WORDS];

    int    inst_count;
    int    store_count;
    int    store_base;
    int    stores_seen;
    int    quiet;
    int    cycles;
    int    limit;

    logic [31:0] lfsr;
    logic        prev_valid;
    logic        prev_stall;
    word_t       prev_address;
    word_t       prev_wrdata;
    logic        prev_write;
    logic        prev_read;

    tb_clock i_clock (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    naive_core i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ibus_address_o (ibus_address),
        .ibus_rddata_i  (ibus_rddata),
        .dbus_address_o (dbus_address),
        .dbus_read_o    (dbus_read),
        .dbus_write_o   (dbus_write),
        .dbus_wrdata_o  (dbus_wrdata),
        .dbus_rddata_i  (dbus_rddata),
        .dbus_stall_i   (dbus_stall)
    );

    task automatic report_mismatch(input string name, input word_t got, input word_t expected);
        $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, expected);
        $display("sim failed");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic abort_run(input string what);
        $display("%0t %s", $time, what);
        $display("sim failed");
        $fatal(1, "%s", what);
    endtask

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Past the program the fetch sees NOPs.
    assign ibus_rddata = (ibus_address[31:2] < inst_count) ?
                         imem[ibus_address[7:2]] : NOP_INST;
    assign dbus_rddata = dmem[dbus_address[7:2]];

    initial begin
        dbus_stall = 1'b0;
        lfsr       = 32'h2424ac49;
        prev_valid = 1'b0;
        stores_seen = 0;
        quiet      = 0;
        for (int i = 0; i < TDATA_WORDS; i++) begin
            tdata[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = '0;
        end
        $readmemh("sim/core_testdata.hex", tdata);
        inst_count  = tdata[0];
        store_count = tdata[inst_count + 1];
        store_base  = inst_count + 2;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < inst_count) ? tdata[i + 1] : NOP_INST;
        end
    end

    // Stall when two fresh LFSR bits are both one.
    always @(posedge clk) begin
        logic b0;
        logic b1;
        if (rst_n) begin
            lfsr = lfsr_step(lfsr);
            b0   = lfsr[0];
            lfsr = lfsr_step(lfsr);
            b1   = lfsr[0];
            dbus_stall <= b0 & b1;
        end
    end

    // Bus sampled mid cycle; an access completes on a cycle without stall.
    always @(negedge clk) begin
        if (rst_n) begin
            if (prev_valid && prev_stall) begin
                assert (dbus_address == prev_address)
                    else report_mismatch("dbus_address_o", dbus_address, prev_address);
                assert (dbus_wrdata == prev_wrdata)
                    else report_mismatch("dbus_wrdata_o", dbus_wrdata, prev_wrdata);
                assert (dbus_write == prev_write)
                    else report_mismatch("dbus_write_o", word_t'(dbus_write),
                                         word_t'(prev_write));
                assert (dbus_read == prev_read)
                    else report_mismatch("dbus_read_o", word_t'(dbus_read),
                                         word_t'(prev_read));
            end
            quiet = quiet + 1;
            if (dbus_write && !dbus_stall) begin
                assert (stores_seen < store_count)
                    else abort_run("store beyond the expected count");
                assert (dbus_address == tdata[store_base + 2 * stores_seen])
                    else report_mismatch("dbus_address_o", dbus_address,
                                         tdata[store_base + 2 * stores_seen]);
                assert (dbus_wrdata == tdata[store_base + 2 * stores_seen + 1])
                    else report_mismatch("dbus_wrdata_o", dbus_wrdata,
                                         tdata[store_base + 2 * stores_seen + 1]);
                dmem[dbus_address[7:2]] = dbus_wrdata;
                stores_seen = stores_seen + 1;
                quiet = 0;
            end
            prev_valid   = 1'b1;
            prev_stall   = dbus_stall;
            prev_address = dbus_address;
            prev_wrdata  = dbus_wrdata;
            prev_write   = dbus_write;
            prev_read    = dbus_read;
        end
    end

    initial begin
        cycles = 0;
        @(posedge rst_n);
        limit = 8 * inst_count + TIMEOUT_SLACK;
        while (!(stores_seen == store_count && quiet >= QUIET_CYCLES)) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > limit) begin
                abort_run("timeout before all expected stores completed");
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: sim/tb_clock.sv
module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        rst_n_o <= 1'b1; // Released on an edge, like any other input.
    end

    always #10 clk_o = ~clk_o;

endmodule

// File: design/naive_core.sv
module naive_core
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output word_t ibus_address_o,
    input  word_t ibus_rddata_i,
    output word_t dbus_address_o,
    output logic  dbus_read_o,
    output logic  dbus_write_o,
    output word_t dbus_wrdata_o,
    input  word_t dbus_rddata_i,
    input  logic  dbus_stall_i
);

    word_t      id_inst;
    word_t      id_pc;
    logic       hold;
    logic       branch_taken;
    word_t      branch_target;
    reg_addr_t  rf_addr_a;
    reg_addr_t  rf_addr_b;
    word_t      rf_a;
    word_t      rf_b;
    alu_op_t    ex_alu_op;
    word_t      ex_a;
    word_t      ex_b;
    imm_t       ex_imm;
    logic       ex_use_imm;
    logic       ex_imm_signed;
    logic [4:0] ex_shamt;
    mem_op_t    ex_mem_op;
    reg_addr_t  ex_dest;
    word_t      ex_fwd_result;
    reg_addr_t  ex_fwd_dest;
    mem_op_t    ex_fwd_mem_op;
    word_t      mm_result;
    word_t      mm_store_data;
    mem_op_t    mm_mem_op;
    reg_addr_t  mm_dest;
    word_t      mm_fwd_result;
    logic       wb_we;
    reg_addr_t  wb_dest;
    word_t      wb_data;

    fetch_unit i_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall_i         (dbus_stall_i),
        .hold_i          (hold),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .inst_i          (ibus_rddata_i),
        .pc_o            (ibus_address_o),
        .id_inst_o       (id_inst),
        .id_pc_o         (id_pc)
    );

    reg_file i_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .we_i      (wb_we),
        .waddr_i   (wb_dest),
        .wdata_i   (wb_data),
        .raddr_a_i (rf_addr_a),
        .raddr_b_i (rf_addr_b),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b)
    );

    decode_stage i_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall_i         (dbus_stall_i),
        .inst_i          (id_inst),
        .pc_i            (id_pc),
        .rf_a_i          (rf_a),
        .rf_b_i          (rf_b),
        .ex_dest_i       (ex_fwd_dest),
        .ex_result_i     (ex_fwd_result),
        .ex_mem_op_i     (ex_fwd_mem_op),
        .mm_dest_i       (mm_dest),
        .mm_result_i     (mm_fwd_result),
        .wb_we_i         (wb_we),
        .wb_dest_i       (wb_dest),
        .wb_data_i       (wb_data),
        .rf_addr_a_o     (rf_addr_a),
        .rf_addr_b_o     (rf_addr_b),
        .hold_o          (hold),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_alu_op_o     (ex_alu_op),
        .ex_a_o          (ex_a),
        .ex_b_o          (ex_b),
        .ex_imm_o        (ex_imm),
        .ex_use_imm_o    (ex_use_imm),
        .ex_imm_signed_o (ex_imm_signed),
        .ex_shamt_o      (ex_shamt),
        .ex_mem_op_o     (ex_mem_op),
        .ex_dest_o       (ex_dest)
    );

    execute_stage i_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall_i         (dbus_stall_i),
        .alu_op_i        (ex_alu_op),
        .a_i             (ex_a),
        .b_i             (ex_b),
        .imm_i           (ex_imm),
        .use_imm_i       (ex_use_imm),
        .imm_signed_i    (ex_imm_signed),
        .shamt_i         (ex_shamt),
        .mem_op_i        (ex_mem_op),
        .dest_i          (ex_dest),
        .result_o        (ex_fwd_result),
        .dest_o          (ex_fwd_dest),
        .mem_op_o        (ex_fwd_mem_op),
        .mm_result_o     (mm_result),
        .mm_store_data_o (mm_store_data),
        .mm_mem_op_o     (mm_mem_op),
        .mm_dest_o       (mm_dest)
    );

    memory_stage i_memory (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_i        (dbus_stall_i),
        .result_i       (mm_result),
        .store_data_i   (mm_store_data),
        .mem_op_i       (mm_mem_op),
        .dest_i         (mm_dest),
        .dbus_rddata_i  (dbus_rddata_i),
        .dbus_address_o (dbus_address_o),
        .dbus_wrdata_o  (dbus_wrdata_o),
        .dbus_read_o    (dbus_read_o),
        .dbus_write_o   (dbus_write_o),
        .mm_result_o    (mm_fwd_result),
        .wb_we_o        (wb_we),
        .wb_dest_o      (wb_dest),
        .wb_data_o      (wb_data)
    );

endmodule

// File: design/memory_stage.sv
module memory_stage
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall_i,
    input  word_t     result_i,
    input  word_t     store_data_i,
    input  mem_op_t   mem_op_i,
    input  reg_addr_t dest_i,
    input  word_t     dbus_rddata_i,
    output word_t     dbus_address_o,
    output word_t     dbus_wrdata_o,
    output logic      dbus_read_o,
    output logic      dbus_write_o,
    output word_t     mm_result_o,
    output logic      wb_we_o,
    output reg_addr_t wb_dest_o,
    output word_t     wb_data_o
);

    // Bus is driven straight from EX/MEM, so it holds on its own during a stall.
    assign dbus_address_o = result_i;
    assign dbus_wrdata_o  = store_data_i;
    assign dbus_read_o    = (mem_op_i == MEM_LOAD);
    assign dbus_write_o   = (mem_op_i == MEM_STORE);

    assign mm_result_o = dbus_read_o ? dbus_rddata_i : result_i;

    // MEM/WB register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we_o   <= 1'b0;
            wb_dest_o <= '0;
        end else if (!stall_i) begin
            wb_we_o   <= (dest_i != '0);
            wb_dest_o <= dest_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_data_o <= mm_result_o;
        end
    end

    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> $stable(dbus_address_o) && $stable(dbus_wrdata_o) &&
                    $stable(dbus_read_o) && $stable(dbus_write_o));

endmodule

// File: design/execute_stage.sv
module execute_stage
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall_i,
    input  alu_op_t    alu_op_i,
    input  word_t      a_i,
    input  word_t      b_i,
    input  imm_t       imm_i,
    input  logic       use_imm_i,
    input  logic       imm_signed_i,
    input  logic [4:0] shamt_i,
    input  mem_op_t    mem_op_i,
    input  reg_addr_t  dest_i,
    output word_t      result_o,
    output reg_addr_t  dest_o,
    output mem_op_t    mem_op_o,
    output word_t      mm_result_o,
    output word_t      mm_store_data_o,
    output mem_op_t    mm_mem_op_o,
    output reg_addr_t  mm_dest_o
);

    word_t imm_ext;
    word_t alu_b;

    assign imm_ext = imm_signed_i ? {{16{imm_i[15]}}, imm_i} : {16'h0000, imm_i};
    assign alu_b   = use_imm_i ? imm_ext : b_i;

    // Loads and stores arrive as ALU_ADD with the signed offset.
    always_comb begin
        case (alu_op_i)
            ALU_ADD: result_o = a_i + alu_b;
            ALU_SUB: result_o = a_i - alu_b;
            ALU_AND: result_o = a_i & alu_b;
            ALU_OR:  result_o = a_i | alu_b;
            ALU_XOR: result_o = a_i ^ alu_b;
            ALU_SLT: result_o = {31'b0, $signed(a_i) < $signed(alu_b)};
            ALU_SLL: result_o = b_i << shamt_i;
            ALU_LUI: result_o = {imm_i, 16'h0000};
            default: result_o = '0;
        endcase
    end

    assign dest_o   = dest_i;
    assign mem_op_o = mem_op_i;

    // EX/MEM register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mm_mem_op_o <= MEM_NONE;
            mm_dest_o   <= '0;
        end else if (!stall_i) begin
            mm_mem_op_o <= mem_op_i;
            mm_dest_o   <= dest_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            mm_result_o     <= result_o;
            mm_store_data_o <= b_i; // rt value.
        end
    end

    // A store must never write back, or forwarding would pick up its address.
    a_store_no_dest: assert property (@(posedge clk) disable iff (!rst_n)
        mm_mem_op_o == MEM_STORE |-> mm_dest_o == '0);

endmodule

// File: design/decode_stage.sv
module decode_stage
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall_i,
    input  word_t     inst_i,
    input  word_t     pc_i,
    input  word_t     rf_a_i,
    input  word_t     rf_b_i,
    input  reg_addr_t ex_dest_i,
    input  word_t     ex_result_i,
    input  mem_op_t   ex_mem_op_i,
    input  reg_addr_t mm_dest_i,
    input  word_t     mm_result_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_dest_i,
    input  word_t     wb_data_i,
    output reg_addr_t rf_addr_a_o,
    output reg_addr_t rf_addr_b_o,
    output logic      hold_o,
    output logic      branch_taken_o,
    output word_t     branch_target_o,
    output alu_op_t   ex_alu_op_o,
    output word_t     ex_a_o,
    output word_t     ex_b_o,
    output imm_t      ex_imm_o,
    output logic      ex_use_imm_o,
    output logic      ex_imm_signed_o,
    output logic [4:0] ex_shamt_o,
    output mem_op_t   ex_mem_op_o,
    output reg_addr_t ex_dest_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    imm_t       imm;
    alu_op_t    alu_op;
    mem_op_t    mem_op;
    reg_addr_t  dest;
    logic       use_imm;
    logic       imm_signed;
    logic       uses_rs;
    logic       uses_rt;
    logic       is_beq;
    logic       is_bne;
    word_t      op_a;
    word_t      op_b;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign funct  = inst_i[5:0];
    assign imm    = inst_i[15:0];

    assign rf_addr_a_o = rs;
    assign rf_addr_b_o = rt;

    always_comb begin
        alu_op     = ALU_ADD;
        mem_op     = MEM_NONE;
        dest       = '0;
        use_imm    = 1'b0;
        imm_signed = 1'b0;
        uses_rs    = 1'b0;
        uses_rt    = 1'b0;
        is_beq     = 1'b0;
        is_bne     = 1'b0;
        case (opcode)
            OPC_SPECIAL: begin
                dest    = rd;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                case (funct)
                    FN_SLL: begin
                        alu_op  = ALU_SLL;
                        uses_rs = 1'b0;
                    end
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: begin // Unknown, behaves as NOP.
                        dest    = '0;
                        uses_rs = 1'b0;
                        uses_rt = 1'b0;
                    end
                endcase
            end
            OPC_BEQ, OPC_BNE: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                is_beq  = (opcode == OPC_BEQ);
                is_bne  = (opcode == OPC_BNE);
            end
            OPC_ADDIU, OPC_LW: begin
                use_imm    = 1'b1;
                imm_signed = 1'b1;
                uses_rs    = 1'b1;
                dest       = rt;
                mem_op     = (opcode == OPC_LW) ? MEM_LOAD : MEM_NONE;
            end
            OPC_ORI: begin
                alu_op  = ALU_OR;
                use_imm = 1'b1;
                uses_rs = 1'b1;
                dest    = rt;
            end
            OPC_LUI: begin
                alu_op = ALU_LUI;
                dest   = rt;
            end
            OPC_SW: begin
                use_imm    = 1'b1;
                imm_signed = 1'b1;
                uses_rs    = 1'b1;
                uses_rt    = 1'b1;
                mem_op     = MEM_STORE;
            end
            default: ;
        endcase
    end

    // Youngest producer wins. A load in execute is caught by the interlock.
    function automatic word_t fwd_operand(input reg_addr_t src, input word_t rf_val);
        if (src != '0 && src == ex_dest_i) begin
            return ex_result_i;
        end else if (src != '0 && src == mm_dest_i) begin
            return mm_result_i;
        end else if (wb_we_i && src == wb_dest_i) begin
            return wb_data_i;
        end
        return rf_val;
    endfunction

    always_comb begin
        op_a = fwd_operand(rs, rf_a_i);
        op_b = fwd_operand(rt, rf_b_i);
    end

    assign hold_o = (ex_mem_op_i == MEM_LOAD) && (ex_dest_i != '0) &&
                    ((uses_rs && rs == ex_dest_i) || (uses_rt && rt == ex_dest_i));

    assign branch_taken_o  = (is_beq && op_a == op_b) || (is_bne && op_a != op_b);
    assign branch_target_o = pc_i + 32'd4 + {{14{imm[15]}}, imm, 2'b00};

    // ID/EX register. A held instruction leaves a bubble behind it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_alu_op_o     <= ALU_ADD;
            ex_use_imm_o    <= 1'b0;
            ex_imm_signed_o <= 1'b0;
            ex_mem_op_o     <= MEM_NONE;
            ex_dest_o       <= '0;
        end else if (!stall_i) begin
            ex_alu_op_o     <= hold_o ? ALU_ADD : alu_op;
            ex_use_imm_o    <= use_imm && !hold_o;
            ex_imm_signed_o <= imm_signed;
            ex_mem_op_o     <= hold_o ? MEM_NONE : mem_op;
            ex_dest_o       <= hold_o ? reg_addr_t'('0) : dest;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex_a_o     <= op_a;
            ex_b_o     <= op_b;
            ex_imm_o   <= imm;
            ex_shamt_o <= inst_i[10:6];
        end
    end

endmodule

// File: design/reg_file.sv
module reg_file
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    output word_t     rdata_a_o,
    output word_t     rdata_b_o
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 is hardwired.
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// File: design/fetch_unit.sv
module fetch_unit
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stall_i,
    input  logic  hold_i,
    input  logic  branch_taken_i,
    input  word_t branch_target_i,
    input  word_t inst_i,
    output word_t pc_o,
    output word_t id_inst_o,
    output word_t id_pc_o
);

    word_t pc;
    logic  advance;

    assign advance = !stall_i && !hold_i;
    assign pc_o    = pc;

    // Fetch address. The delay slot is already being fetched when a branch resolves.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (advance) begin
            if (branch_taken_i) begin
                pc <= branch_target_i;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // IF/ID register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_inst_o <= NOP_INST;
            id_pc_o   <= RESET_PC;
        end else if (advance) begin
            id_inst_o <= inst_i;
            id_pc_o   <= pc;
        end
    end

    // Branch targets come from decode and must keep fetch aligned.
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// File: design/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam word_t NOP_INST = 32'h0000_0000; // SLL r0, r0, 0.

    localparam int REG_COUNT = 32;

    // Primary opcodes, inst[31:26].
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    // Function codes of SPECIAL, inst[5:0].
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage
